// File: source/decode_params.svh
// Decode stage parameters
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data, address and PC width
`define WORD_W 32

// Register file index width
`define REG_IDX_W 5

// RV32I major opcodes
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011

// Custom opcode that stops the core
`define OPC_HALT   7'h7F

`endif

// File: source/decode_pkg.sv
// Decode stage types
`include "decode_params.svh"

package decode_pkg;

  // Plain vectors with a meaning
  typedef logic [`WORD_W-1:0]    word_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // ALU operations, ADD must stay zero so a bubble is a harmless add
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } aluop_t;

  // ALU port A source
  typedef enum logic [1:0] {
    A_RS1   = 2'd0,
    A_IMM_S = 2'd1,
    A_PC    = 2'd2,
    A_ZERO  = 2'd3
  } a_sel_t;

  // ALU port B source
  typedef enum logic [1:0] {
    B_RS1   = 2'd0,
    B_RS2   = 2'd1,
    B_IMM   = 2'd2,
    B_IMM_U = 2'd3
  } b_sel_t;

  // Register write-back source
  typedef enum logic [1:0] {
    W_ALU   = 2'd0,
    W_PC4   = 2'd1,
    W_IMM_U = 2'd2,
    W_LOAD  = 2'd3
  } w_sel_t;

  // Branch kinds, encoded as funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_t;

  // Load widths, encoded as funct3
  typedef enum logic [2:0] {
    LD_B  = 3'b000,
    LD_H  = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_t;

  typedef struct packed {
    logic flush;
    logic stall;
    logic pc_en;
  } hazard_t;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    aluop_t   alu_op;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    w_sel_t   w_sel;
    logic     shamt_sel;
    logic     j_sel;
    logic     wen;
    logic     dwen;
    logic     dren;
    load_t    load_type;
    logic     jump;
    logic     branch;
    branch_t  branch_type;
    logic     halt;
  } ctrl_t;

  typedef struct packed {
    word_t imm_i;
    word_t imm_s;
    word_t imm_sb;
    word_t imm_u;
    word_t imm_uj;
    word_t shamt;
  } imm_t;

  typedef struct packed {
    reg_idx_t reg_rs1;
    reg_idx_t reg_rs2;
    reg_idx_t reg_rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    port_a;
    word_t    port_b;
    aluop_t   alu_op;
    word_t    wdata;
    w_sel_t   w_sel;
    logic     wen;
    logic     dwen;
    logic     dren;
    load_t    load_type;
    logic     jump;
    logic     j_sel;
    word_t    j_base;
    word_t    j_offset;
    logic     branch;
    branch_t  branch_type;
    word_t    br_imm_sb;
    logic     halt_instr;
    word_t    pc;
    word_t    pc4;
  } id_ex_t;

endpackage

// File: source/control_decoder.sv
// Instruction control decoder
`timescale 1ns/1ps
`include "decode_params.svh"

module control_decoder (
  input  decode_pkg::word_t instr,
  output decode_pkg::ctrl_t ctrl
);

  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  // Bit 30 picks SUB over ADD and SRA over SRL
  assign funct7_b5 = instr[30];

  // Shared ALU op lookup for register and immediate forms
  function automatic aluop_t alu_from_funct(input logic [2:0] f3, input logic alt,
                                            input logic allow_sub);
    aluop_t op;
    case (f3)
      3'b000:  op = (alt && allow_sub) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;

    // Register indices come straight from the fixed fields
    ctrl.rs1 = instr[19:15];
    ctrl.rs2 = instr[24:20];
    ctrl.rd  = instr[11:7];

    case (opcode)
      `OPC_OP: begin
        ctrl.alu_op = alu_from_funct(funct3, funct7_b5, 1'b1);
        ctrl.a_sel  = A_RS1;
        ctrl.b_sel  = B_RS2;
        ctrl.w_sel  = W_ALU;
        ctrl.wen    = 1'b1;
      end

      `OPC_OPIMM: begin
        // No SUBI, bit 30 belongs to the immediate unless shifting
        ctrl.alu_op    = alu_from_funct(funct3, funct7_b5, 1'b0);
        ctrl.a_sel     = A_RS1;
        ctrl.b_sel     = B_IMM;
        ctrl.w_sel     = W_ALU;
        ctrl.wen       = 1'b1;
        ctrl.shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
      end

      `OPC_LUI: begin
        ctrl.alu_op = ALU_ADD;
        ctrl.a_sel  = A_ZERO;
        ctrl.b_sel  = B_IMM_U;
        ctrl.w_sel  = W_IMM_U;
        ctrl.wen    = 1'b1;
      end

      `OPC_AUIPC: begin
        ctrl.alu_op = ALU_ADD;
        ctrl.a_sel  = A_PC;
        ctrl.b_sel  = B_IMM_U;
        ctrl.w_sel  = W_ALU;
        ctrl.wen    = 1'b1;
      end

      `OPC_LOAD: begin
        // Address is rs1 plus the I immediate
        ctrl.alu_op    = ALU_ADD;
        ctrl.a_sel     = A_RS1;
        ctrl.b_sel     = B_IMM;
        ctrl.w_sel     = W_LOAD;
        ctrl.wen       = 1'b1;
        ctrl.dren      = 1'b1;
        ctrl.load_type = load_t'(funct3);
      end

      `OPC_STORE: begin
        // Address is the S immediate plus rs1, rs2 carries the data
        ctrl.alu_op = ALU_ADD;
        ctrl.a_sel  = A_IMM_S;
        ctrl.b_sel  = B_RS1;
        ctrl.dwen   = 1'b1;
      end

      `OPC_BRANCH: begin
        ctrl.alu_op      = ALU_SUB;
        ctrl.a_sel       = A_RS1;
        ctrl.b_sel       = B_RS2;
        ctrl.branch      = 1'b1;
        ctrl.branch_type = branch_t'(funct3);
      end

      `OPC_JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.w_sel = W_PC4;
        ctrl.wen   = 1'b1;
      end

      `OPC_JALR: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b0;
        ctrl.w_sel = W_PC4;
        ctrl.wen   = 1'b1;
      end

      `OPC_HALT: begin
        ctrl.halt = 1'b1;
      end

      default: begin
        // Unknown opcode keeps everything inactive
        ctrl.halt = 1'b0;
      end
    endcase
  end

endmodule

// File: source/imm_generator.sv
// Immediate generator
`timescale 1ns/1ps
`include "decode_params.svh"

module imm_generator (
  input  decode_pkg::word_t instr,
  output decode_pkg::imm_t  imm
);

  import decode_pkg::*;

  logic sign;

  assign sign = instr[31];

  // I type
  assign imm.imm_i = {{(`WORD_W-12){sign}}, instr[31:20]};

  // S type, split around rd field
  assign imm.imm_s = {{(`WORD_W-12){sign}}, instr[31:25], instr[11:7]};

  // SB type, always even
  assign imm.imm_sb = {{(`WORD_W-13){sign}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};

  // U type sits in the upper twenty bits
  assign imm.imm_u = {instr[31:12], 12'b0};

  // UJ type, always even
  assign imm.imm_uj = {{(`WORD_W-21){sign}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};

  // Shift amount is unsigned
  assign imm.shamt = {{(`WORD_W-5){1'b0}}, instr[24:20]};

endmodule

// File: source/id_ex_register.sv
// Decode to execute pipeline register
`timescale 1ns/1ps

module id_ex_register (
  input  logic                CLK,
  input  logic                nRST,
  input  decode_pkg::ctrl_t   ctrl,
  input  decode_pkg::imm_t    imm,
  input  decode_pkg::fetch_t  fetch,
  input  decode_pkg::hazard_t hazard,
  input  logic                halt,
  input  decode_pkg::word_t   rs1_data,
  input  decode_pkg::word_t   rs2_data,
  output decode_pkg::id_ex_t  id_ex
);

  import decode_pkg::*;

  word_t  imm_or_shamt;
  word_t  port_a;
  word_t  port_b;
  word_t  j_base;
  word_t  j_offset;
  word_t  wdata;
  id_ex_t next;
  logic   bubble;
  logic   load_en;

  // Shift immediates use only the shamt field
  assign imm_or_shamt = ctrl.shamt_sel ? imm.shamt : imm.imm_i;

  always_comb begin
    case (ctrl.a_sel)
      A_RS1:   port_a = rs1_data;
      A_IMM_S: port_a = imm.imm_s;
      A_PC:    port_a = fetch.pc;
      default: port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.b_sel)
      B_RS1:   port_b = rs1_data;
      B_RS2:   port_b = rs2_data;
      B_IMM:   port_b = imm_or_shamt;
      default: port_b = imm.imm_u;
    endcase
  end

  // JAL is pc relative, JALR is register relative
  always_comb begin
    if (ctrl.j_sel) begin
      j_base   = fetch.pc;
      j_offset = imm.imm_uj;
    end else begin
      j_base   = rs1_data;
      j_offset = imm.imm_i;
    end
  end

  // Early write-back value, ALU and load results come later
  always_comb begin
    case (ctrl.w_sel)
      W_PC4:   wdata = fetch.pc4;
      W_IMM_U: wdata = imm.imm_u;
      default: wdata = '0;
    endcase
  end

  always_comb begin
    next             = '0;
    next.reg_rs1     = ctrl.rs1;
    next.reg_rs2     = ctrl.rs2;
    next.reg_rd      = ctrl.rd;
    next.rs1_data    = rs1_data;
    next.rs2_data    = rs2_data;
    next.port_a      = port_a;
    next.port_b      = port_b;
    next.alu_op      = ctrl.alu_op;
    next.wdata       = wdata;
    next.w_sel       = ctrl.w_sel;
    next.wen         = ctrl.wen;
    next.dwen        = ctrl.dwen;
    next.dren        = ctrl.dren;
    next.load_type   = ctrl.load_type;
    next.jump        = ctrl.jump;
    next.j_sel       = ctrl.j_sel;
    next.j_base      = j_base;
    next.j_offset    = j_offset;
    next.branch      = ctrl.branch;
    next.branch_type = ctrl.branch_type;
    next.br_imm_sb   = imm.imm_sb;
    next.halt_instr  = ctrl.halt;
    next.pc          = fetch.pc;
    next.pc4         = fetch.pc4;
  end

  // Flush or stall only bubble when the pipe advances
  assign bubble  = ((hazard.flush | hazard.stall) & hazard.pc_en) | halt;
  assign load_en = hazard.pc_en & ~hazard.stall;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex <= '0;
    end else if (bubble) begin
      id_ex <= '0;
    end else if (load_en) begin
      id_ex <= next;
    end
  end

endmodule

// File: source/decode_stage.sv
// RV32I decode stage
`timescale 1ns/1ps

module decode_stage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  decode_pkg::fetch_t   fetch,
  input  decode_pkg::hazard_t  hazard,
  input  logic                 halt,
  input  decode_pkg::word_t    rs1_data,
  input  decode_pkg::word_t    rs2_data,
  output decode_pkg::reg_idx_t rs1,
  output decode_pkg::reg_idx_t rs2,
  output logic                 decode_halt,
  output decode_pkg::id_ex_t   id_ex
);

  import decode_pkg::*;

  ctrl_t ctrl;
  imm_t  imm;

  control_decoder u_control_decoder (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  imm_generator u_imm_generator (
    .instr (fetch.instr),
    .imm   (imm)
  );

  id_ex_register u_id_ex_register (
    .CLK      (CLK),
    .nRST     (nRST),
    .ctrl     (ctrl),
    .imm      (imm),
    .fetch    (fetch),
    .hazard   (hazard),
    .halt     (halt),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .id_ex    (id_ex)
  );

  // Register file read addresses
  assign rs1 = ctrl.rs1;
  assign rs2 = ctrl.rs2;

  // Halt seen in decode goes to the hazard unit right away
  assign decode_halt = ctrl.halt;

endmodule

// File: bench/decode_stage_assertions.sv
// Decode stage checker
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage_assertions (
  input logic                 CLK,
  input logic                 nRST,
  input decode_pkg::fetch_t   fetch,
  input decode_pkg::hazard_t  hazard,
  input logic                 halt,
  input decode_pkg::word_t    rs1_data,
  input decode_pkg::reg_idx_t rs1,
  input decode_pkg::reg_idx_t rs2,
  input logic                 decode_halt,
  input decode_pkg::id_ex_t   id_ex
);

  import decode_pkg::*;

  typedef logic [$bits(id_ex_t)-1:0] wide_t;

  logic   failed = 1'b0;
  string  fail_name;
  wide_t  fail_exp;
  wide_t  fail_got;

  // Inputs seen at the previous edge
  word_t  p_instr;
  word_t  p_pc;
  word_t  p_pc4;
  word_t  p_r1;
  id_ex_t p_id_ex;
  logic [6:0] p_opc;

  logic   load_c;
  logic   bubble_c;
  logic   hold_c;
  logic   opc_ab;
  word_t  imm_i;
  word_t  imm_s;
  word_t  imm_u;
  word_t  imm_uj;
  word_t  exp_a;
  word_t  exp_b;

  function automatic void record_failure(input string name, input wide_t e, input wide_t g);
    if (!failed) begin
      fail_name = name;
      fail_exp  = e;
      fail_got  = g;
      failed    = 1'b1;
    end
    $error("check on %s failed", name);
  endfunction

  always_ff @(posedge CLK) begin
    p_instr <= fetch.instr;
    p_pc    <= fetch.pc;
    p_pc4   <= fetch.pc4;
    p_r1    <= rs1_data;
    p_id_ex <= id_ex;
  end

  assign p_opc = p_instr[6:0];

  // Pipeline register actions for the current inputs
  assign bubble_c = nRST && (((hazard.flush || hazard.stall) && hazard.pc_en) || halt);
  assign load_c   = nRST && !bubble_c && hazard.pc_en && !hazard.stall;
  assign hold_c   = nRST && !hazard.pc_en && !hazard.flush && !hazard.stall && !halt;

  // RV32I immediate formats
  assign imm_i  = word_t'($signed(p_instr[31:20]));
  assign imm_s  = word_t'($signed({p_instr[31:25], p_instr[11:7]}));
  assign imm_u  = {p_instr[31:12], 12'h000};
  assign imm_uj = word_t'($signed({p_instr[31], p_instr[19:12], p_instr[20],
                                   p_instr[30:21], 1'b0}));

  assign opc_ab = (p_opc == `OPC_OPIMM) || (p_opc == `OPC_LOAD) ||
                  (p_opc == `OPC_STORE) || (p_opc == `OPC_AUIPC);

  always_comb begin
    exp_a = '0;
    exp_b = '0;
    case (p_opc)
      `OPC_OPIMM: begin
        exp_a = p_r1;
        // funct3 001 and 101 are the shifts
        exp_b = (p_instr[13:12] == 2'b01) ? {27'd0, p_instr[24:20]} : imm_i;
      end
      `OPC_LOAD: begin
        exp_a = p_r1;
        exp_b = imm_i;
      end
      `OPC_STORE: begin
        exp_a = imm_s;
        exp_b = p_r1;
      end
      `OPC_AUIPC: begin
        exp_a = p_pc;
        exp_b = imm_u;
      end
      default: begin
        exp_a = '0;
      end
    endcase
  end

  a_reset_low: assert property (@(posedge CLK) !nRST |-> id_ex == '0)
    else record_failure("id_ex", '0, $sampled(id_ex));

  a_reset_release: assert property (@(posedge CLK) $rose(nRST) |-> id_ex == '0)
    else record_failure("id_ex", '0, $sampled(id_ex));

  a_rs1: assert property (@(posedge CLK) rs1 == fetch.instr[19:15])
    else record_failure("rs1", $sampled(fetch.instr[19:15]), $sampled(rs1));

  a_rs2: assert property (@(posedge CLK) rs2 == fetch.instr[24:20])
    else record_failure("rs2", $sampled(fetch.instr[24:20]), $sampled(rs2));

  a_decode_halt: assert property (@(posedge CLK)
    decode_halt == (fetch.instr[6:0] == `OPC_HALT))
    else record_failure("decode_halt", $sampled(fetch.instr[6:0] == `OPC_HALT),
                        $sampled(decode_halt));

  a_port_a: assert property (@(posedge CLK) disable iff (!nRST)
    $past(load_c) && opc_ab |-> id_ex.port_a == exp_a)
    else record_failure("port_a", $sampled(exp_a), $sampled(id_ex.port_a));

  a_port_b: assert property (@(posedge CLK) disable iff (!nRST)
    $past(load_c) && opc_ab |-> id_ex.port_b == exp_b)
    else record_failure("port_b", $sampled(exp_b), $sampled(id_ex.port_b));

  a_rd_pc: assert property (@(posedge CLK) disable iff (!nRST)
    $past(load_c) && opc_ab |-> {id_ex.reg_rd, id_ex.pc, id_ex.pc4} ==
                                {p_instr[11:7], p_pc, p_pc4})
    else record_failure("reg_rd/pc/pc4", $sampled({p_instr[11:7], p_pc, p_pc4}),
                        $sampled({id_ex.reg_rd, id_ex.pc, id_ex.pc4}));

  a_lui: assert property (@(posedge CLK) disable iff (!nRST)
    $past(load_c) && p_opc == `OPC_LUI |-> id_ex.wdata == imm_u)
    else record_failure("wdata", $sampled(imm_u), $sampled(id_ex.wdata));

  a_jal: assert property (@(posedge CLK) disable iff (!nRST)
    $past(load_c) && p_opc == `OPC_JAL |->
      {id_ex.j_base, id_ex.j_offset, id_ex.wdata} == {p_pc, imm_uj, p_pc4})
    else record_failure("j_base/j_offset/wdata", $sampled({p_pc, imm_uj, p_pc4}),
                        $sampled({id_ex.j_base, id_ex.j_offset, id_ex.wdata}));

  a_jalr: assert property (@(posedge CLK) disable iff (!nRST)
    $past(load_c) && p_opc == `OPC_JALR |->
      {id_ex.j_base, id_ex.j_offset} == {p_r1, imm_i})
    else record_failure("j_base/j_offset", $sampled({p_r1, imm_i}),
                        $sampled({id_ex.j_base, id_ex.j_offset}));

  a_bubble: assert property (@(posedge CLK) disable iff (!nRST)
    $past(bubble_c) |-> id_ex == '0)
    else record_failure("id_ex", '0, $sampled(id_ex));

  a_hold: assert property (@(posedge CLK) disable iff (!nRST)
    $past(hold_c) |-> id_ex == p_id_ex)
    else record_failure("id_ex", $sampled(p_id_ex), $sampled(id_ex));

endmodule

// File: bench/decode_stage_tb.sv
// Decode stage testbench
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage_tb;

  import decode_pkg::*;

  localparam int NUM_CYCLES   = 600;
  localparam int CYCLE_LIMIT  = 2000;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_OPC      = 11;

  logic     CLK;
  logic     nRST;
  fetch_t   fetch;
  hazard_t  hazard;
  logic     halt;
  word_t    rs1_data;
  word_t    rs2_data;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     decode_halt;
  id_ex_t   id_ex;

  logic [31:0] rng_state;
  logic [6:0]  templates [NUM_OPC];

  bind decode_stage decode_stage_assertions u_assertions (.*);

  decode_stage UUT (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch       (fetch),
    .hazard      (hazard),
    .halt        (halt),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1         (rs1),
    .rs2         (rs2),
    .decode_halt (decode_halt),
    .id_ex       (id_ex)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Random fields under an opcode template, plus random data and controls
  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] h;
    r           = next_rand();
    fetch.instr = {r[31:7], templates[next_rand() % NUM_OPC]};
    fetch.pc    = next_rand() & 32'hFFFF_FFFC;
    fetch.pc4   = fetch.pc + 32'd4;
    rs1_data    = next_rand();
    rs2_data    = next_rand();
    h           = next_rand();
    hazard.pc_en = (h[2:0] != 3'd0);
    hazard.stall = (h[6:4] == 3'd0);
    hazard.flush = (h[10:8] == 3'd0);
    halt         = (h[15:11] == 5'd0);
  endtask

  // First failure from the checker ends the run
  always @(negedge CLK) begin
    if (UUT.u_assertions.failed) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time,
               UUT.u_assertions.fail_name, UUT.u_assertions.fail_exp,
               UUT.u_assertions.fail_got);
      $display("=== FAIL ===");
      $fatal(1, "stopping at first check failure");
    end
  end

  // Watchdog
  initial begin
    for (int i = 0; i < CYCLE_LIMIT; i++) begin
      @(posedge CLK);
    end
    $display("Timeout: the run did not finish within the cycle limit");
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial begin
    templates = '{`OPC_OP, `OPC_OPIMM, `OPC_LUI, `OPC_AUIPC, `OPC_LOAD, `OPC_STORE,
                  `OPC_BRANCH, `OPC_JAL, `OPC_JALR, `OPC_HALT, 7'h0B};
    rng_state = 32'h7b700421;
    CLK       = 1'b0;
    nRST      = 1'b1;
    fetch     = '0;
    hazard    = '0;
    halt      = 1'b0;
    rs1_data  = '0;
    rs2_data  = '0;
    #2 nRST = 1'b0;

    // Reset with random inputs so the all-zero output means something
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge CLK);
      #5 drive_random();
    end
    nRST = 1'b1;

    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge CLK);
      #5 drive_random();
    end

    // Let the last checks complete
    for (int i = 0; i < 3; i++) begin
      @(negedge CLK);
    end

    if (UUT.u_assertions.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "check failure at end of run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: tb.f
+incdir+source
source/decode_pkg.sv
source/control_decoder.sv
source/imm_generator.sv
source/id_ex_register.sv
source/decode_stage.sv
bench/decode_stage_assertions.sv
bench/decode_stage_tb.sv
